/* hdl/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// instruction and address width
`define WORD_SIZE 16
// one cache line, four words
`define QWORD_SIZE 64

// address split: | tag | index | offset |
`define OFFSET_BITS 2
`define INDEX_BITS 4    // 16 lines
`define TAG_BITS 10

`define RESET_PC 16'h0000

`endif

/* hdl/fetch_pkg.sv */
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

    typedef logic [`WORD_SIZE-1:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [`QWORD_SIZE/`WORD_SIZE-1:0] line_t;

    typedef logic [`INDEX_BITS-1:0] index_t;
    typedef logic [`OFFSET_BITS-1:0] offset_t;
    typedef logic [`TAG_BITS-1:0] tag_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // miss fill sequence
    typedef enum logic [1:0] {
        lookup,
        request,     // waiting for m1_ready
        wait_ack,    // read_m1 high
        write_line
    } fill_state_t;

endpackage

`default_nettype wire

/* hdl/fetch_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fetch_if;
    import fetch_pkg::*;

    word_t pc;      // current fetch pc
    logic  hit;     // line for pc present
    line_t line;    // line read at pc index
    logic  take;    // fetch accepted this cycle

    modport counter (
        input  take,
        output pc
    );

    modport cache (
        input  pc,
        output hit,
        output line
    );

    modport buffer (
        input  pc,
        input  hit,
        input  line,
        output take
    );

endinterface

`default_nettype wire

/* hdl/line_store_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface line_store_if #(
    parameter type entry_t = fetch_pkg::line_t
);
    import fetch_pkg::*;

    // read side, combinational
    index_t rd_index;
    entry_t rd_entry;

    // write side, lands at the clock edge
    logic   wr_en;
    index_t wr_index;
    entry_t wr_entry;

    modport ctrl (
        output rd_index,
        input  rd_entry,
        output wr_en,
        output wr_index,
        output wr_entry
    );

    modport store (
        input  rd_index,
        output rd_entry,
        input  wr_en,
        input  wr_index,
        input  wr_entry
    );

endinterface

`default_nettype wire

/* hdl/line_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module line_store #(
    parameter type entry_t = fetch_pkg::line_t
) (
    input  wire logic   clk,
    input  wire logic   reset_n,
    line_store_if.store st
);
    localparam int DEPTH = 1 << `INDEX_BITS;

    entry_t mem [0:DEPTH-1];

    assign st.rd_entry = mem[st.rd_index];

    // cleared entries read back as invalid tags
    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (st.wr_en) begin
            mem[st.wr_index] <= st.wr_entry;
        end
    end

    a_wr_index_known: assert property (
        @(posedge clk) disable iff (reset_n)
        st.wr_en |-> !$isunknown(st.wr_index)
    ) else $error("line_store write with unknown index");

endmodule

`default_nettype wire

/* hdl/pc_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module pc_counter (
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire logic             redirect,
    input  wire fetch_pkg::word_t redirect_pc,
    fetch_if.counter              fc
);
    import fetch_pkg::*;

    word_t pc_q;

    assign fc.pc = pc_q;

    ////////////////////////////////////////////////////////////////////////////
    // next pc, redirect wins over a fetch

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc_q <= word_t'(`RESET_PC);
        end else if (redirect) begin
            pc_q <= redirect_pc;
        end else if (fc.take) begin
            pc_q <= pc_q + 1'b1;   // no branches, just step
        end
    end

endmodule

`default_nettype wire

/* hdl/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module icache_ctrl (
    input  wire logic             clk,
    input  wire logic             reset_n,
    fetch_if.cache                fc,
    line_store_if.ctrl            tag_bus,
    line_store_if.ctrl            line_bus,
    input  wire logic             m1_ready,
    input  wire logic             m1_ack,
    input  wire fetch_pkg::line_t qdata1,
    output logic                  read_m1,
    output fetch_pkg::word_t      address1
);
    import fetch_pkg::*;

    tag_t        pc_tag;
    index_t      pc_index;
    tag_entry_t  tag_rd;
    tag_entry_t  new_tag;
    logic        tag_match;
    fill_state_t state;
    fill_state_t state_next;
    word_t       miss_addr;
    line_t       fill_line;

    ////////////////////////////////////////////////////////////////////////////
    // lookup

    assign pc_tag   = fc.pc[`WORD_SIZE-1 -: `TAG_BITS];
    assign pc_index = fc.pc[`OFFSET_BITS +: `INDEX_BITS];

    assign tag_bus.rd_index  = pc_index;
    assign line_bus.rd_index = pc_index;

    assign tag_rd    = tag_bus.rd_entry;
    assign tag_match = tag_rd.valid && (tag_rd.tag == pc_tag);

    // no hit while a fill owns the cache
    assign fc.hit  = (state == lookup) && tag_match;
    assign fc.line = line_bus.rd_entry;

    ////////////////////////////////////////////////////////////////////////////
    // fill

    assign new_tag.valid = 1'b1;
    assign new_tag.tag   = miss_addr[`WORD_SIZE-1 -: `TAG_BITS];

    assign tag_bus.wr_en     = (state == write_line);
    assign tag_bus.wr_index  = miss_addr[`OFFSET_BITS +: `INDEX_BITS];
    assign tag_bus.wr_entry  = new_tag;
    assign line_bus.wr_en    = (state == write_line);
    assign line_bus.wr_index = miss_addr[`OFFSET_BITS +: `INDEX_BITS];
    assign line_bus.wr_entry = fill_line;

    assign address1 = miss_addr;

    always_comb begin
        state_next = state;
        case (state)
            lookup: begin
                if (!tag_match) begin
                    state_next = request;
                end
            end
            request: begin
                if (m1_ready) begin
                    state_next = wait_ack;
                end
            end
            wait_ack: begin
                if (m1_ack) begin
                    state_next = write_line;
                end
            end
            default: state_next = lookup;   // write_line lasts one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state   <= lookup;
            read_m1 <= 1'b0;
        end else begin
            state <= state_next;
            if (state == request && m1_ready) begin
                read_m1 <= 1'b1;
            end else if (state == wait_ack && m1_ack) begin
                read_m1 <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == lookup && !tag_match) begin
            miss_addr <= {fc.pc[`WORD_SIZE-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
        end
        if (state == wait_ack && m1_ack) begin
            fill_line <= qdata1;   // qdata1 valid with the ack
        end
    end

    a_addr_stable: assert property (
        @(posedge clk) disable iff (reset_n)
        read_m1 |=> !read_m1 || $stable(address1)
    ) else $error("address1 changed while read_m1 was high");

    a_no_read_in_lookup: assert property (
        @(posedge clk) disable iff (reset_n)
        state == lookup |-> !read_m1
    ) else $error("read_m1 high during lookup");

endmodule

`default_nettype wire

/* hdl/fetch_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_buffer (
    input  wire logic        clk,
    input  wire logic        reset_n,
    input  wire logic        stall,
    input  wire logic        redirect,
    fetch_if.buffer          fb,
    output logic             inst_valid,
    output fetch_pkg::word_t inst,
    output fetch_pkg::word_t inst_pc,
    output fetch_pkg::word_t num_fetched
);
    import fetch_pkg::*;

    offset_t off;
    word_t   sel_word;

    // stall holds everything, redirect drops the current pc
    assign fb.take = fb.hit && !stall && !redirect;

    assign off      = fb.pc[`OFFSET_BITS-1:0];
    assign sel_word = fb.line[off];

    ////////////////////////////////////////////////////////////////////////////
    // IF/ID register

    always_ff @(posedge clk) begin
        if (reset_n) begin
            inst_valid <= 1'b0;
        end else if (fb.take) begin
            inst_valid <= 1'b1;
        end else if (redirect) begin
            inst_valid <= 1'b0;   // old path squashed
        end
    end

    always_ff @(posedge clk) begin
        if (fb.take) begin
            inst    <= sel_word;
            inst_pc <= fb.pc;
        end
    end

    // delivered count, wraps
    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_fetched <= '0;
        end else if (fb.take) begin
            num_fetched <= num_fetched + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire logic             m1_ready,
    input  wire logic             m1_ack,
    input  wire fetch_pkg::line_t qdata1,
    input  wire logic             redirect,
    input  wire fetch_pkg::word_t redirect_pc,
    input  wire logic             stall,
    output logic                  read_m1,
    output fetch_pkg::word_t      address1,
    output logic                  inst_valid,
    output fetch_pkg::word_t      inst,
    output fetch_pkg::word_t      inst_pc,
    output fetch_pkg::word_t      num_fetched
);
    import fetch_pkg::*;

    fetch_if fbus ();

    line_store_if #(.entry_t(tag_entry_t)) tag_bus ();
    line_store_if #(.entry_t(line_t))      line_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // pc and cache

    pc_counter u_pc (
        .clk         (clk),
        .reset_n     (reset_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fc          (fbus.counter)
    );

    icache_ctrl u_icache (
        .clk      (clk),
        .reset_n  (reset_n),
        .fc       (fbus.cache),
        .tag_bus  (tag_bus.ctrl),
        .line_bus (line_bus.ctrl),
        .m1_ready (m1_ready),
        .m1_ack   (m1_ack),
        .qdata1   (qdata1),
        .read_m1  (read_m1),
        .address1 (address1)
    );

    line_store #(.entry_t(tag_entry_t)) tag_store (
        .clk     (clk),
        .reset_n (reset_n),
        .st      (tag_bus.store)
    );

    line_store #(.entry_t(line_t)) data_store (
        .clk     (clk),
        .reset_n (reset_n),
        .st      (line_bus.store)
    );

    ////////////////////////////////////////////////////////////////////////////
    // fetch register

    fetch_buffer u_fbuf (
        .clk         (clk),
        .reset_n     (reset_n),
        .stall       (stall),
        .redirect    (redirect),
        .fb          (fbus.buffer),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .num_fetched (num_fetched)
    );

endmodule

`default_nettype wire

/* tests/main_memory_model.sv */
`timescale 1ns/1ps
`default_nettype none

module main_memory_model (
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire logic             read_m1,
    input  wire fetch_pkg::word_t address1,
    output fetch_pkg::line_t      qdata1,
    output logic                  m1_ready,
    output logic                  m1_ack
);
    import fetch_pkg::*;

    localparam word_t DATA_KEY = 16'h5a3c;

    int unsigned ready_wait;
    int unsigned ack_wait;
    logic        busy;

    // word at address a holds a ^ key, word 0 in the low bits
    function automatic line_t read_line(input word_t base);
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k] = word_t'(base + k) ^ DATA_KEY;
        end
        return l;
    endfunction

    initial begin
        m1_ready = 1'b0;
        m1_ack   = 1'b0;
        qdata1   = '0;
    end

    always @(negedge clk) begin
        if (reset_n) begin
            m1_ready   <= 1'b0;
            m1_ack     <= 1'b0;
            busy       <= 1'b0;
            ready_wait <= $urandom_range(0, 3);
        end else begin
            m1_ack <= 1'b0;
            if (busy) begin
                if (ack_wait > 1) begin
                    ack_wait <= ack_wait - 1;
                end else begin
                    m1_ack     <= 1'b1;   // data goes with the ack
                    qdata1     <= read_line(address1);
                    busy       <= 1'b0;
                    m1_ready   <= 1'b0;
                    ready_wait <= $urandom_range(0, 3);
                end
            end else if (read_m1) begin
                busy     <= 1'b1;
                ack_wait <= $urandom_range(1, 4);
            end else if (ready_wait != 0) begin
                ready_wait <= ready_wait - 1;
            end else begin
                m1_ready <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit;
    import fetch_pkg::*;

    localparam word_t DATA_KEY      = 16'h5a3c;
    localparam word_t START_PC      = 16'h0000;
    localparam int    SEQ_WORDS     = 40;
    localparam int    REVISIT_WORDS = 8;
    localparam int    REDIR_TESTS   = 12;
    localparam int    REDIR_WORDS   = 6;
    localparam int    STALL_BURSTS  = 10;
    localparam int    MISS_COST     = 10;
    localparam int    MAX_CYCLES    = (SEQ_WORDS + REVISIT_WORDS + REDIR_TESTS * REDIR_WORDS
                                       + 2 * STALL_BURSTS) * MISS_COST + 300;

    logic  clk, reset_n, m1_ready, m1_ack, redirect, stall, read_m1, inst_valid;
    line_t qdata1;
    word_t redirect_pc, address1, inst, inst_pc, num_fetched;

    // state seen at the previous edge
    logic        in_reset_q, prev_valid, prev_read, hold_q, redirect_q;
    word_t       prev_pc, prev_inst, exp_pc;
    logic [15:0] res_valid;          // lines the cache should hold
    logic [9:0]  res_tag [0:15];
    logic        new_inst, resident;
    int          delivered;
    int          errors = 0;
    int          cycles = 0;

    fetch_unit dut0 (
        .clk (clk), .reset_n (reset_n), .m1_ready (m1_ready), .m1_ack (m1_ack),
        .qdata1 (qdata1), .redirect (redirect), .redirect_pc (redirect_pc), .stall (stall),
        .read_m1 (read_m1), .address1 (address1), .inst_valid (inst_valid), .inst (inst),
        .inst_pc (inst_pc), .num_fetched (num_fetched)
    );

    main_memory_model mem0 (
        .clk (clk), .reset_n (reset_n), .read_m1 (read_m1), .address1 (address1),
        .qdata1 (qdata1), .m1_ready (m1_ready), .m1_ack (m1_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    assign new_inst = inst_valid && (!prev_valid || inst_pc != prev_pc);
    assign resident = res_valid[address1[5:2]] && res_tag[address1[5:2]] == address1[15:6];

    always @(posedge clk) begin
        in_reset_q <= reset_n;
        if (reset_n) begin
            {prev_valid, prev_read, hold_q, redirect_q} <= '0;
            prev_pc   <= '0;
            prev_inst <= '0;
            exp_pc    <= START_PC;
            delivered <= 0;
            res_valid <= '0;
        end else begin
            prev_valid <= inst_valid;
            prev_pc    <= inst_pc;
            prev_inst  <= inst;
            prev_read  <= read_m1;
            hold_q     <= stall && !redirect;
            redirect_q <= redirect;
            if (new_inst) delivered <= delivered + 1;
            if (redirect) exp_pc <= redirect_pc;
            else if (new_inst) exp_pc <= exp_pc + 1'b1;
            if (read_m1 && m1_ack) begin
                res_valid[address1[5:2]] <= 1'b1;
                res_tag[address1[5:2]]   <= address1[15:6];
            end
        end
    end

    task automatic record_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks

    a_reset: assert property (@(posedge clk) in_reset_q && !reset_n |->
        !read_m1 && !inst_valid && num_fetched == 0)
        else record_error($sformatf("mismatch reset expected %h actual %h",
            18'h0, {$sampled(read_m1), $sampled(inst_valid), $sampled(num_fetched)}));
    a_data: assert property (@(posedge clk) disable iff (reset_n)
        inst_valid |-> inst == (inst_pc ^ DATA_KEY))
        else record_error($sformatf("mismatch sequential expected %h actual %h",
            $sampled(inst_pc) ^ DATA_KEY, $sampled(inst)));
    a_order: assert property (@(posedge clk) disable iff (reset_n) new_inst |-> inst_pc == exp_pc)
        else record_error($sformatf("mismatch pc_order expected %h actual %h",
            $sampled(exp_pc), $sampled(inst_pc)));
    a_aligned: assert property (@(posedge clk) disable iff (reset_n)
        read_m1 |-> address1[1:0] == 2'b00)
        else record_error($sformatf("mismatch line_fetch expected %h actual %h",
            {$sampled(address1[15:2]), 2'b00}, $sampled(address1)));
    a_refetch: assert property (@(posedge clk) disable iff (reset_n)
        read_m1 && !prev_read |-> !resident)
        else record_error($sformatf("line %h read again while still cached",
            $sampled(address1)));
    a_squash: assert property (@(posedge clk) disable iff (reset_n) redirect_q |-> !inst_valid)
        else record_error("inst_valid stayed high after a redirect");
    a_hold: assert property (@(posedge clk) disable iff (reset_n) hold_q |->
        inst_valid == prev_valid && (!inst_valid || {inst, inst_pc} == {prev_inst, prev_pc}))
        else record_error($sformatf("mismatch stall expected %h actual %h",
            {$sampled(prev_valid), $sampled(prev_inst), $sampled(prev_pc)},
            {$sampled(inst_valid), $sampled(inst), $sampled(inst_pc)}));
    a_count: assert property (@(posedge clk) disable iff (reset_n)
        num_fetched == word_t'(delivered + new_inst))
        else record_error($sformatf("mismatch count expected %0d actual %0d",
            word_t'($sampled(delivered) + $sampled(new_inst)), $sampled(num_fetched)));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d instructions delivered, %0d errors",
                cycles, delivered, errors);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic wait_words(input int n);
        int target;
        target = delivered + n;
        while (delivered < target) @(negedge clk);
    endtask

    task automatic do_redirect(input word_t target);
        redirect    = 1'b1;
        redirect_pc = target;
        @(negedge clk);
        redirect    = 1'b0;
    endtask

    task automatic run_stall_bursts(input int bursts);
        int len;
        for (int i = 0; i < bursts; i++) begin
            wait_words(2);
            len   = $urandom_range(1, 4);
            stall = 1'b1;
            repeat (len) @(negedge clk);
            stall = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(32'hb2a31bf4));
        reset_n     = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        stall       = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b0;
        wait_words(SEQ_WORDS);
        do_redirect(16'h0008);   // lines 0..9 are still resident
        wait_words(REVISIT_WORDS);
        repeat (REDIR_TESTS) begin
            do_redirect(word_t'($urandom));
            wait_words(REDIR_WORDS);
        end
        run_stall_bursts(STALL_BURSTS);
        repeat (4) @(negedge clk);
        $display("%0d instructions delivered, %0d errors", delivered, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_if.sv
hdl/line_store_if.sv
hdl/line_store.sv
hdl/pc_counter.sv
hdl/icache_ctrl.sv
hdl/fetch_buffer.sv
hdl/fetch_unit.sv
tests/main_memory_model.sv
tests/tb_fetch_unit.sv
